/* verilog/dbus_pkg.sv */
`default_nettype none

// Core data bus widths and the memory map entry for the CLINT
package dbus_pkg;

    // ----------------------------------------
    // Bus widths
    // ----------------------------------------

    // Data word width, one RV32 register
    localparam int unsigned XLEN = 32;

    // Byte address width on the data bus
    localparam int unsigned DBUS_ADDR_W = 32;

    // ----------------------------------------
    // Memory map
    // ----------------------------------------

    // Default CLINT window base, the usual RISC-V location
    // Must be aligned to the CLINT window size
    localparam logic [DBUS_ADDR_W-1:0] CLINT_BASE_DEFAULT = 32'h0200_0000;

endpackage : dbus_pkg

`default_nettype wire

/* verilog/clint_pkg.sv */
`default_nettype none

// CLINT window geometry, register map and timer defaults
package clint_pkg;

    // ----------------------------------------
    // Window
    // ----------------------------------------

    // Offset bits inside the CLINT window, 64 KB
    localparam int unsigned CLINT_ADDR_WIDTH = 16;

    // ----------------------------------------
    // Register map
    // ----------------------------------------

    // Word offsets of the CLINT registers
    // Standard SiFive-style layout for a single hart
    typedef enum logic [CLINT_ADDR_WIDTH-1:0] {
        // Software interrupt pending, bit 0 only
        MSIP_R          = 16'h0000,
        // Timer compare value, low and high words
        MTIMECMP_LOW_R  = 16'h4000,
        MTIMECMP_HIGH_R = 16'h4004,
        // Free-running timer, low and high words
        MTIME_LOW_R     = 16'hBFF8,
        MTIME_HIGH_R    = 16'hBFFC
    } clint_reg_e;

    // ----------------------------------------
    // Timer
    // ----------------------------------------

    // System clocks per mtime increment
    localparam int unsigned PRESCALE_DEFAULT = 100;

endpackage : clint_pkg

`default_nettype wire

/* verilog/timer_prescaler.sv */
`timescale 1ns/1ns
`default_nettype none

// Clock-enable divider for the mtime counter
// Stays in the clk domain, no derived clock
module timer_prescaler #(
    // System clocks per tick, 1 or more
    parameter int unsigned PRESCALE = 1
) (
    input  wire logic clk,
    input  wire logic rst_n,
    output logic      tick_o
);

    // Counter wide enough for PRESCALE-1, at least one bit
    localparam int unsigned CNT_W = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

    // Terminal count, tick fires here
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(PRESCALE - 1);

    logic [CNT_W-1:0] cnt_q;
    logic             wrap;

    // Wrap on the terminal count
    // With PRESCALE 1 the counter sits at zero and this is always true
    assign wrap = (cnt_q == LAST_CNT);

    // ----------------------------------------
    // Free-running counter
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (wrap) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // One-cycle enable, first one PRESCALE cycles after reset
    assign tick_o = wrap;

endmodule : timer_prescaler

`default_nettype wire

/* verilog/clint.sv */
`timescale 1ns/1ns
`default_nettype none

// Core-local interruptor for one hart
// Holds mtime, mtimecmp and msip behind a word-only register port
module clint
    import dbus_pkg::*, clint_pkg::*;
#(
    // System clocks per mtime increment
    parameter int unsigned PRESCALE = PRESCALE_DEFAULT
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,

    // Register port from the bus decoder
    input  wire logic                        clint_sel_i,
    input  wire logic                        we_i,
    input  wire logic [CLINT_ADDR_WIDTH-1:0] addr_offset_i,
    input  wire logic [XLEN-1:0]             wdata_i,
    output logic      [XLEN-1:0]             rdata_o,
    output logic                             ack_o,

    // Interrupts to MIP
    output logic                             timer_irq_o,
    output logic                             soft_irq_o,

    // Full timer value for the time CSRs
    output logic      [63:0]                 mtime_o
);

    // Request qualifiers
    logic             r_req;
    logic             w_req;
    clint_reg_e       reg_offset;

    // Write flags per register half
    logic             mtime_lo_wr;
    logic             mtime_hi_wr;
    logic             mtimecmp_lo_wr;
    logic             mtimecmp_hi_wr;
    logic             msip_wr;

    // Architectural state
    logic [63:0]      mtime_q;
    logic [63:0]      mtimecmp_q;
    logic             msip_q;
    logic             timer_irq_q;

    // Read path
    logic [XLEN-1:0]  rd_data;
    logic [XLEN-1:0]  rdata_q;
    logic             rd_ack_q;

    // mtime increment enable
    logic             tick;

    // ----------------------------------------
    // Request decode
    // ----------------------------------------
    assign r_req      = clint_sel_i & ~we_i;
    assign w_req      = clint_sel_i &  we_i;
    assign reg_offset = clint_reg_e'(addr_offset_i);

    // One flag per writable word, unused offsets write nothing
    always_comb begin
        mtime_lo_wr    = 1'b0;
        mtime_hi_wr    = 1'b0;
        mtimecmp_lo_wr = 1'b0;
        mtimecmp_hi_wr = 1'b0;
        msip_wr        = 1'b0;
        if (w_req) begin
            case (reg_offset)
                MSIP_R:          msip_wr        = 1'b1;
                MTIMECMP_LOW_R:  mtimecmp_lo_wr = 1'b1;
                MTIMECMP_HIGH_R: mtimecmp_hi_wr = 1'b1;
                MTIME_LOW_R:     mtime_lo_wr    = 1'b1;
                MTIME_HIGH_R:    mtime_hi_wr    = 1'b1;
                default: ;
            endcase
        end
    end

    // Read mux, unused offsets read zero
    always_comb begin
        case (reg_offset)
            MSIP_R:          rd_data = {{(XLEN-1){1'b0}}, msip_q};
            MTIMECMP_LOW_R:  rd_data = mtimecmp_q[31:0];
            MTIMECMP_HIGH_R: rd_data = mtimecmp_q[63:32];
            MTIME_LOW_R:     rd_data = mtime_q[31:0];
            MTIME_HIGH_R:    rd_data = mtime_q[63:32];
            default:         rd_data = '0;
        endcase
    end

    // ----------------------------------------
    // Timer
    // ----------------------------------------
    timer_prescaler #(
        .PRESCALE (PRESCALE)
    ) u_prescaler (
        .clk    (clk),
        .rst_n  (rst_n),
        .tick_o (tick)
    );

    // A half write wins over the tick on the same edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime_q <= '0;
        end else if (mtime_lo_wr) begin
            mtime_q[31:0] <= wdata_i;
        end else if (mtime_hi_wr) begin
            mtime_q[63:32] <= wdata_i;
        end else if (tick) begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    // Compare value and software interrupt bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtimecmp_q <= '0;
            msip_q     <= 1'b0;
        end else begin
            if (mtimecmp_lo_wr) begin
                mtimecmp_q[31:0] <= wdata_i;
            end
            if (mtimecmp_hi_wr) begin
                mtimecmp_q[63:32] <= wdata_i;
            end
            if (msip_wr) begin
                msip_q <= wdata_i[0];
            end
        end
    end

    // Timer interrupt, one cycle behind the registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timer_irq_q <= 1'b0;
        end else begin
            timer_irq_q <= (mtime_q >= mtimecmp_q);
        end
    end

    // ----------------------------------------
    // Bus response
    // ----------------------------------------

    // Read ack one cycle late, dropped for a cycle if stb is held
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ack_q <= 1'b0;
        end else begin
            rd_ack_q <= r_req & ~rd_ack_q;
        end
    end

    // Read data captured with the ack
    always_ff @(posedge clk) begin
        if (r_req && !rd_ack_q) begin
            rdata_q <= rd_data;
        end
    end

    // Writes ack in the request cycle
    assign ack_o   = w_req | rd_ack_q;
    assign rdata_o = rdata_q;

    // Outputs
    assign timer_irq_o = timer_irq_q;
    assign soft_irq_o  = msip_q;
    assign mtime_o     = mtime_q;

endmodule : clint

`default_nettype wire

/* verilog/dbus_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

// Data bus address decode in front of the CLINT
// Anything outside the CLINT window ends in a bus error
module dbus_decoder
    import dbus_pkg::*, clint_pkg::*;
#(
    // Window base, aligned to the window size
    parameter logic [DBUS_ADDR_W-1:0] CLINT_BASE = CLINT_BASE_DEFAULT
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,

    // Master side, Wishbone classic
    input  wire logic                        cyc_i,
    input  wire logic                        stb_i,
    input  wire logic                        we_i,
    input  wire logic [DBUS_ADDR_W-1:0]      adr_i,
    output logic      [XLEN-1:0]             dat_o,
    output logic                             ack_o,
    output logic                             err_o,

    // CLINT side
    output logic                             clint_sel_o,
    output logic      [CLINT_ADDR_WIDTH-1:0] addr_offset_o,
    input  wire logic [XLEN-1:0]             clint_rdata_i,
    input  wire logic                        clint_ack_i
);

    // Upper address bits that identify the window
    localparam int unsigned TAG_W = DBUS_ADDR_W - CLINT_ADDR_WIDTH;
    localparam logic [TAG_W-1:0] BASE_TAG = CLINT_BASE[DBUS_ADDR_W-1:CLINT_ADDR_WIDTH];

    logic req;
    logic hit;
    logic miss;
    logic err_q;

    // ----------------------------------------
    // Decode
    // ----------------------------------------
    assign req  = cyc_i & stb_i;
    assign hit  = (adr_i[DBUS_ADDR_W-1:CLINT_ADDR_WIDTH] == BASE_TAG);
    assign miss = req & ~hit;

    // Request to the CLINT only inside the window
    assign clint_sel_o   = req & hit;
    assign addr_offset_o = adr_i[CLINT_ADDR_WIDTH-1:0];

    // ----------------------------------------
    // Error response
    // ----------------------------------------

    // One cycle after the miss
    // Low for a cycle if the master holds stb past the error
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_q <= 1'b0;
        end else begin
            err_q <= miss & ~err_q;
        end
    end

    // ----------------------------------------
    // Response mux
    // ----------------------------------------

    // CLINT answers on a hit, error register on a miss
    assign ack_o = hit & clint_ack_i;
    assign err_o = err_q;

    // Read data only for in-window reads, zero otherwise
    assign dat_o = (hit && !we_i) ? clint_rdata_i : '0;

endmodule : dbus_decoder

`default_nettype wire

/* verilog/clint_subsys_top.sv */
`timescale 1ns/1ns
`default_nettype none

// CLINT subsystem, decoder plus CLINT on one Wishbone slave port
module clint_subsys_top
    import dbus_pkg::*, clint_pkg::*;
#(
    // System clocks per mtime increment
    parameter int unsigned            PRESCALE   = PRESCALE_DEFAULT,
    // CLINT window base
    parameter logic [DBUS_ADDR_W-1:0] CLINT_BASE = CLINT_BASE_DEFAULT
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,

    // Wishbone classic slave
    input  wire logic                   wb_cyc_i,
    input  wire logic                   wb_stb_i,
    input  wire logic                   wb_we_i,
    input  wire logic [DBUS_ADDR_W-1:0] wb_adr_i,
    input  wire logic [XLEN-1:0]        wb_dat_i,
    // Full-word accesses only, byte lanes ignored
    input  wire logic [XLEN/8-1:0]      wb_sel_i,
    output logic      [XLEN-1:0]        wb_dat_o,
    output logic                        wb_ack_o,
    output logic                        wb_err_o,

    // To the core
    output logic                        timer_irq_o,
    output logic                        soft_irq_o,
    output logic      [63:0]            mtime_o
);

    // Decoder to CLINT
    logic                        clint_sel;
    logic [CLINT_ADDR_WIDTH-1:0] addr_offset;
    logic [XLEN-1:0]             clint_rdata;
    logic                        clint_ack;

    // ----------------------------------------
    // Address decode
    // ----------------------------------------
    dbus_decoder #(
        .CLINT_BASE (CLINT_BASE)
    ) u_decoder (
        .clk           (clk),
        .rst_n         (rst_n),
        .cyc_i         (wb_cyc_i),
        .stb_i         (wb_stb_i),
        .we_i          (wb_we_i),
        .adr_i         (wb_adr_i),
        .dat_o         (wb_dat_o),
        .ack_o         (wb_ack_o),
        .err_o         (wb_err_o),
        .clint_sel_o   (clint_sel),
        .addr_offset_o (addr_offset),
        .clint_rdata_i (clint_rdata),
        .clint_ack_i   (clint_ack)
    );

    // ----------------------------------------
    // CLINT
    // ----------------------------------------

    // Write enable and data straight from the bus
    clint #(
        .PRESCALE (PRESCALE)
    ) u_clint (
        .clk           (clk),
        .rst_n         (rst_n),
        .clint_sel_i   (clint_sel),
        .we_i          (wb_we_i),
        .addr_offset_i (addr_offset),
        .wdata_i       (wb_dat_i),
        .rdata_o       (clint_rdata),
        .ack_o         (clint_ack),
        .timer_irq_o   (timer_irq_o),
        .soft_irq_o    (soft_irq_o),
        .mtime_o       (mtime_o)
    );

endmodule : clint_subsys_top

`default_nettype wire

/* verification/tb_clk_gen.sv */
`timescale 1ns/1ns
`default_nettype none

// Clock and power-on reset for the testbench
module tb_clk_gen #(
    parameter int unsigned HALF_PERIOD  = 5,
    parameter int unsigned RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_n_o
);

    // Free-running clock, 10 ns period by default
    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // Reset held for RESET_CYCLES rising edges
    // Released on a falling edge, away from the DUT's sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule : tb_clk_gen

`default_nettype wire

/* verification/clint_tb.sv */
`timescale 1ns/1ns
`default_nettype none

// Testbench for the CLINT subsystem behind its Wishbone port
module clint_tb
    import dbus_pkg::*, clint_pkg::*;
;

    localparam int unsigned SEED         = 97755;
    localparam int unsigned TB_PRESCALE  = 8;
    localparam int unsigned RESP_LIMIT   = 8;
    localparam int unsigned GAP          = 4;
    // Upper bound on bus accesses issued below
    localparam int unsigned NUM_ACCESSES = 80;
    localparam int unsigned WATCHDOG_CYC = 20 * NUM_ACCESSES * 8 + 2000;

    logic            clk;
    logic            rst_n;
    logic            wb_cyc;
    logic            wb_stb;
    logic            wb_we;
    logic [31:0]     wb_adr;
    logic [31:0]     wb_dat_w;
    logic [3:0]      wb_sel;
    logic [31:0]     wb_dat_r;
    logic            wb_ack;
    logic            wb_err;
    logic            timer_irq;
    logic            soft_irq;
    logic [63:0]     mtime;

    // Reference model state
    logic [63:0]     cmp_m    = '0;
    logic            msip_m   = 1'b0;
    logic [31:0]     mt_lo_m  = '0;
    logic [31:0]     mt_hi_m  = '0;
    int              mt_lo_cyc = 0;
    int              mt_hi_cyc = 0;

    // Bookkeeping for the compare process
    int              cycle_cnt = 0;
    int              resp_cyc;
    int              fail_count = 0;
    logic [63:0]     mtime_snap;
    logic [31:0]     obs_addr;
    logic [31:0]     obs_data;
    logic            obs_err;
    int              obs_cyc;
    event            read_done;

    tb_clk_gen #(
        .HALF_PERIOD  (5),
        .RESET_CYCLES (16)
    ) u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    clint_subsys_top #(
        .PRESCALE   (TB_PRESCALE),
        .CLINT_BASE (CLINT_BASE_DEFAULT)
    ) dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_cyc_i    (wb_cyc),
        .wb_stb_i    (wb_stb),
        .wb_we_i     (wb_we),
        .wb_adr_i    (wb_adr),
        .wb_dat_i    (wb_dat_w),
        .wb_sel_i    (wb_sel),
        .wb_dat_o    (wb_dat_r),
        .wb_ack_o    (wb_ack),
        .wb_err_o    (wb_err),
        .timer_irq_o (timer_irq),
        .soft_irq_o  (soft_irq),
        .mtime_o     (mtime)
    );

    // Cycles since reset release
    always @(posedge clk) begin
        if (rst_n) begin
            cycle_cnt <= cycle_cnt + 1;
        end
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    function automatic logic in_window(input logic [31:0] addr);
        return addr[DBUS_ADDR_W-1:CLINT_ADDR_WIDTH] ==
               CLINT_BASE_DEFAULT[DBUS_ADDR_W-1:CLINT_ADDR_WIDTH];
    endfunction

    function automatic logic [31:0] reg_addr(input logic [15:0] off);
        return {CLINT_BASE_DEFAULT[31:16], off};
    endfunction

    // Bit 32 set means a bus error is expected
    // mtime offsets give the last written value, the lower bound
    function automatic logic [32:0] ref_read(input logic [31:0] addr);
        if (!in_window(addr)) begin
            return {1'b1, 32'h0};
        end
        case (addr[15:0])
            MSIP_R:          return {1'b0, 31'h0, msip_m};
            MTIMECMP_LOW_R:  return {1'b0, cmp_m[31:0]};
            MTIMECMP_HIGH_R: return {1'b0, cmp_m[63:32]};
            MTIME_LOW_R:     return {1'b0, mt_lo_m};
            MTIME_HIGH_R:    return {1'b0, mt_hi_m};
            default:         return {1'b0, 32'h0};
        endcase
    endfunction

    // Ticks that may have landed since the half was written
    function automatic logic [31:0] mtime_slack(input logic [31:0] addr, input int cyc);
        if (addr[15:0] == MTIME_LOW_R) begin
            return 32'((cyc - mt_lo_cyc) / 8 + 1);
        end
        return 32'((cyc - mt_hi_cyc) / 8 + 1);
    endfunction

    task automatic model_write(input logic [31:0] addr, input logic [31:0] data, input int cyc);
        case (addr[15:0])
            MSIP_R:          msip_m = data[0];
            MTIMECMP_LOW_R:  cmp_m[31:0] = data;
            MTIMECMP_HIGH_R: cmp_m[63:32] = data;
            MTIME_LOW_R: begin
                mt_lo_m   = data;
                mt_lo_cyc = cyc;
            end
            MTIME_HIGH_R: begin
                mt_hi_m   = data;
                mt_hi_cyc = cyc;
            end
            default: ;
        endcase
    endtask

    // ----------------------------------------
    // Failure handling and checks
    // ----------------------------------------

    task automatic abort_run(input string why);
        fail_count++;
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] want);
        if (got !== want) begin
            abort_run($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, want));
        end
    endtask

    // Compares every completed read with the model
    always @(read_done) begin : compare_reads
        logic [32:0] want;
        logic [31:0] slack;
        logic [31:0] diff;
        want = ref_read(obs_addr);
        check("wb_err_o", 64'(obs_err), 64'(want[32]));
        if (!want[32] && (obs_addr[15:0] == MTIME_LOW_R || obs_addr[15:0] == MTIME_HIGH_R)) begin
            slack = mtime_slack(obs_addr, obs_cyc);
            // Modulo distance, so a low-half wrap still counts as progress
            diff  = obs_data - want[31:0];
            check("wb_dat_o (mtime)", 64'(obs_data),
                  (diff <= slack) ? 64'(obs_data) : 64'(want[31:0] + slack));
        end else begin
            check("wb_dat_o", 64'(obs_data), 64'(want[31:0]));
        end
    end

    // ----------------------------------------
    // Bus master
    // ----------------------------------------

    // One classic cycle, driven on the falling edge
    task automatic bus_cycle(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic got_err);
        int waited;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = addr;
        wb_dat_w = wdata;
        wb_sel   = 4'hF;
        #1;
        mtime_snap = mtime;
        waited     = 0;
        while (!wb_ack && !wb_err) begin
            if (waited == RESP_LIMIT) begin
                abort_run($sformatf("no bus response within %0d cycles, address 0x%08h",
                                    RESP_LIMIT, addr));
            end
            @(negedge clk);
            #1;
            waited++;
        end
        check("wb_ack_o", 64'(wb_ack), 64'(in_window(addr)));
        check("wb_err_o", 64'(wb_err), 64'(!in_window(addr)));
        // In-window writes answer at once, reads and errors one cycle later
        check("wb response latency", 64'(waited), (we && in_window(addr)) ? 64'h0 : 64'h1);
        rdata   = wb_dat_r;
        got_err = wb_err;
        // Response taken on this edge
        @(posedge clk);
        @(negedge clk);
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        resp_cyc = cycle_cnt;
    endtask

    task automatic wb_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] rd_ignored;
        logic        err;
        bus_cycle(1'b1, addr, data, rd_ignored, err);
        if (in_window(addr)) begin
            model_write(addr, data, resp_cyc);
        end
    endtask

    task automatic wb_read(input logic [31:0] addr, output logic [31:0] data);
        logic err;
        bus_cycle(1'b0, addr, 32'h0, data, err);
        obs_addr = addr;
        obs_data = data;
        obs_err  = err;
        obs_cyc  = resp_cyc;
        -> read_done;
    endtask

    task automatic read_all_regs;
        logic [31:0] rd;
        wb_read(reg_addr(MSIP_R), rd);
        wb_read(reg_addr(MTIMECMP_LOW_R), rd);
        wb_read(reg_addr(MTIMECMP_HIGH_R), rd);
        wb_read(reg_addr(MTIME_LOW_R), rd);
        wb_read(reg_addr(MTIME_HIGH_R), rd);
    endtask

    // Hang guard, scaled to the number of accesses
    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        abort_run("watchdog expired before the tests finished");
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin : main_seq
        logic [31:0] data;
        logic [31:0] rd;
        logic [31:0] addr;
        logic [15:0] off;
        int          waited;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_sel   = '0;
        void'($urandom(SEED));

        // Reset state
        @(posedge rst_n);
        #1;
        check("timer_irq_o", 64'(timer_irq), 64'h0);
        check("soft_irq_o", 64'(soft_irq), 64'h0);
        check("wb_ack_o", 64'(wb_ack), 64'h0);
        check("wb_err_o", 64'(wb_err), 64'h0);
        read_all_regs();
        check("mtime_o", mtime, (mtime <= 64'(cycle_cnt / 8)) ? mtime : 64'(cycle_cnt / 8));

        // mtimecmp and msip round trip
        for (int i = 0; i < 4; i++) begin
            data = $urandom;
            wb_write(reg_addr(MTIMECMP_LOW_R), data);
            data = $urandom;
            wb_write(reg_addr(MTIMECMP_HIGH_R), data);
            data = $urandom;
            wb_write(reg_addr(MSIP_R), data);
            check("soft_irq_o", 64'(soft_irq), 64'(msip_m));
            wb_read(reg_addr(MSIP_R), rd);
            wb_read(reg_addr(MTIMECMP_LOW_R), rd);
            wb_read(reg_addr(MTIMECMP_HIGH_R), rd);
        end
        // Unused offsets, kept clear of the register map
        for (int i = 0; i < 2; i++) begin
            off = 16'h1000 | (16'($urandom) & 16'h2FFC);
            wb_write(reg_addr(off), $urandom);
            wb_read(reg_addr(off), rd);
        end
        read_all_regs();

        // mtime load and prescaled advance
        for (int i = 0; i < 4; i++) begin
            wb_write(reg_addr(MTIME_LOW_R), $urandom);
            repeat ($urandom_range(40)) @(negedge clk);
            wb_read(reg_addr(MTIME_LOW_R), rd);
            check("mtime_o[31:0]", 64'(mtime_snap[31:0]), 64'(rd));
            wb_write(reg_addr(MTIME_HIGH_R), $urandom);
            repeat ($urandom_range(40)) @(negedge clk);
            wb_read(reg_addr(MTIME_HIGH_R), rd);
            check("mtime_o[63:32]", 64'(mtime_snap[63:32]), 64'(rd));
        end

        // Timer interrupt, low half away from any carry
        wb_write(reg_addr(MTIME_HIGH_R), 32'h0);
        wb_write(reg_addr(MTIME_LOW_R), 32'h100);
        wb_write(reg_addr(MTIMECMP_HIGH_R), 32'hFFFF_FFFF);
        wb_write(reg_addr(MTIMECMP_LOW_R), 32'h0);
        repeat (2) @(negedge clk);
        check("timer_irq_o", 64'(timer_irq), 64'h0);
        wb_read(reg_addr(MTIME_LOW_R), rd);
        wb_write(reg_addr(MTIMECMP_LOW_R), rd + GAP);
        wb_write(reg_addr(MTIMECMP_HIGH_R), 32'h0);
        waited = 0;
        while (!timer_irq) begin
            if (waited == 8 * (GAP + 2)) begin
                abort_run("timer interrupt did not rise after mtime reached mtimecmp");
            end
            @(negedge clk);
            waited++;
        end
        repeat (16) begin
            @(negedge clk);
            check("timer_irq_o", 64'(timer_irq), 64'h1);
        end
        wb_write(reg_addr(MTIMECMP_HIGH_R), 32'hFFFF_FFFF);
        // Compare is registered, one more edge
        @(negedge clk);
        check("timer_irq_o", 64'(timer_irq), 64'h0);

        // Accesses outside the window
        for (int i = 0; i < 8; i++) begin
            addr = $urandom;
            if (in_window(addr)) begin
                addr[31:16] = ~addr[31:16];
            end
            if ($urandom_range(1) == 1) begin
                wb_write(addr, $urandom);
            end else begin
                wb_read(addr, rd);
            end
        end
        read_all_regs();

        // Last read still in the compare process
        @(negedge clk);
        if (fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule : clint_tb

`default_nettype wire

/* flist.f */
verilog/dbus_pkg.sv
verilog/clint_pkg.sv
verilog/timer_prescaler.sv
verilog/clint.sv
verilog/dbus_decoder.sv
verilog/clint_subsys_top.sv
verification/tb_clk_gen.sv
verification/clint_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the CLINT testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ns \
    -f flist.f --top-module clint_tb \
    -Mdir "$BUILD_DIR" -o clint_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/clint_tb_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
exit 0
